// ==== hdl/forth_cfg.svh ====
/* forth dictionary engine configuration
   widths, memory size, chain terminator and command credits */
`ifndef FORTH_CFG_SVH
`define FORTH_CFG_SVH

`define CFG_DSZ        8         // memory byte width
`define CFG_ASZ        16        // byte address width
`define CFG_MEM_DEPTH  65536     // full 64K address space

// link value that terminates the dictionary chain
`define CFG_LINK_END   16'hffff

// empty dictionary after reset so every find misses
`define CFG_CTX_INIT   `CFG_LINK_END

`define CFG_CREDITS    4         // host credits == queue depth
`define CFG_CRED_W     3         // occupancy count width, holds 0..CFG_CREDITS

`endif

// ==== hdl/forth_pkg.sv ====
/* forth dictionary engine shared types
   memory byte and address, command opcodes, search states */
package forth_pkg;

`include "forth_cfg.svh"

    typedef logic [`CFG_DSZ-1:0] byte_t;   // one dictionary byte
    typedef logic [`CFG_ASZ-1:0] addr_t;   // one byte address

    typedef enum logic [1:0] {
        R1   = 2'd0,    // read one byte
        W1   = 2'd1,    // write one byte
        CTX  = 2'd2,    // load context pointer
        FIND = 2'd3     // search for counted string
    } pool_op_e;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,  // serve queue head
        LNK_LO = 3'd1,  // link low byte address out
        LNK_HI = 3'd2,  // link high byte address out
        LEN    = 3'd3,  // length byte address out
        NAME   = 3'd4,  // name byte address out
        TIB    = 3'd5,  // tib byte address out
        CMP    = 3'd6,  // compare name vs tib byte
        DONE   = 3'd7   // register response
    } find_st_e;

endpackage

// ==== hdl/dict_mem.sv ====
/* dictionary memory
   single-port byte RAM, registered read, read-before-write */
`timescale 1ns/100ps
`include "forth_cfg.svh"

module dict_mem (
    input  logic             clk,
    input  logic             we,
    input  forth_pkg::addr_t addr,
    input  forth_pkg::byte_t wdata,
    output forth_pkg::byte_t rdata
);
    forth_pkg::byte_t mem [`CFG_MEM_DEPTH];  // whole address space

    // start from an all-zero dictionary space
    initial begin
        for (int i = 0; i < `CFG_MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];                  // old data on a write cycle
    end

endmodule

// ==== hdl/pool_cmd_queue.sv ====
/* command queue in front of the search engine
   depth matches the host credits, one credit back per dispatch */
`timescale 1ns/100ps
`include "forth_cfg.svh"

module pool_cmd_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  forth_pkg::pool_op_e cmd_op,
    input  forth_pkg::addr_t    cmd_addr,
    input  forth_pkg::byte_t    cmd_data,
    output logic                cmd_credit,
    output logic                q_valid,
    input  logic                q_ready,
    output forth_pkg::pool_op_e q_op,
    output forth_pkg::addr_t    q_addr,
    output forth_pkg::byte_t    q_data
);
    localparam int DEPTH = `CFG_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    forth_pkg::pool_op_e op_q   [DEPTH];    // entry payload
    forth_pkg::addr_t    addr_q [DEPTH];
    forth_pkg::byte_t    data_q [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [`CFG_CRED_W-1:0] cnt;            // occupancy
    logic                pop;

    // circular increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign q_valid = (cnt != '0);
    assign pop     = q_valid && q_ready;    // head taken by engine
    assign q_op    = op_q[rd_ptr];
    assign q_addr  = addr_q[rd_ptr];
    assign q_data  = data_q[rd_ptr];

    // no full check, host credits bound the occupancy
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            op_q[wr_ptr]   <= cmd_op;
            addr_q[wr_ptr] <= cmd_addr;
            data_q[wr_ptr] <= cmd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            cnt        <= '0;
            cmd_credit <= 1'b0;
        end else begin
            cmd_credit <= pop;              // one credit per dispatch
            if (cmd_valid) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({cmd_valid, pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;        // both or neither
            endcase
        end
    end

endmodule

// ==== hdl/dict_pool.sv ====
/* dictionary search engine and memory arbiter
   serves byte read/write, holds the context pointer, walks the chain on find */
`timescale 1ns/100ps
`include "forth_cfg.svh"

module dict_pool (
    input  logic                clk,
    input  logic                rst,
    input  logic                q_valid,
    input  forth_pkg::pool_op_e q_op,
    input  forth_pkg::addr_t    q_addr,
    input  forth_pkg::byte_t    q_data,
    output logic                q_ready,
    input  forth_pkg::byte_t    mem_rdata,
    output logic                mem_we,
    output forth_pkg::addr_t    mem_addr,
    output forth_pkg::byte_t    mem_wdata,
    output logic                rsp_valid,
    output forth_pkg::pool_op_e rsp_op,
    output forth_pkg::byte_t    rsp_data,
    output logic                rsp_hit,
    output forth_pkg::addr_t    rsp_pfa
);
    forth_pkg::find_st_e st;
    forth_pkg::find_st_e st_nxt;
    forth_pkg::addr_t    ctx;        // newest entry
    forth_pkg::addr_t    ptr;        // link, length, name walker
    forth_pkg::addr_t    tib;        // counted string base
    forth_pkg::addr_t    tptr;       // current tib byte
    forth_pkg::addr_t    lnk;        // next entry
    forth_pkg::addr_t    pfa;        // candidate pfa
    forth_pkg::byte_t    rem;        // name bytes left
    forth_pkg::byte_t    prev;       // name byte held for compare
    forth_pkg::pool_op_e cur_op;
    logic                at_len;     // compare pass is on the length byte
    logic                hit;
    logic                pop;
    logic                same;
    logic                chain_end;

    assign pop       = q_valid && q_ready;
    assign same      = (prev == mem_rdata);                        // name vs tib
    assign chain_end = (ptr == forth_pkg::addr_t'(`CFG_LINK_END));

    always_ff @(posedge clk) begin
        if (rst) st <= forth_pkg::IDLE;
        else st <= st_nxt;
    end

    // next state
    always_comb begin
        st_nxt = st;
        case (st)
            forth_pkg::IDLE: begin
                if (pop && q_op == forth_pkg::R1) begin
                    st_nxt = forth_pkg::DONE;       // one cycle for read data
                end else if (pop && q_op == forth_pkg::FIND) begin
                    st_nxt = forth_pkg::LNK_LO;
                end
            end
            forth_pkg::LNK_LO: st_nxt = chain_end ? forth_pkg::DONE : forth_pkg::LNK_HI;
            forth_pkg::LNK_HI: st_nxt = forth_pkg::LEN;
            forth_pkg::LEN:    st_nxt = forth_pkg::TIB;     // length byte acts as name byte 0
            forth_pkg::NAME:   st_nxt = forth_pkg::TIB;
            forth_pkg::TIB:    st_nxt = forth_pkg::CMP;
            forth_pkg::CMP: begin
                if (!same) begin
                    st_nxt = forth_pkg::LNK_LO;     // next entry, end checked there
                end else if (rem == '0) begin
                    st_nxt = forth_pkg::DONE;       // whole name matched
                end else begin
                    st_nxt = forth_pkg::NAME;
                end
            end
            forth_pkg::DONE:   st_nxt = forth_pkg::IDLE;
            default:           st_nxt = forth_pkg::IDLE;
        endcase
    end

    // memory access
    assign q_ready   = (st == forth_pkg::IDLE);
    assign mem_we    = pop && (q_op == forth_pkg::W1);
    assign mem_wdata = q_data;

    always_comb begin
        case (st)
            forth_pkg::IDLE:   mem_addr = q_addr;   // host read/write
            forth_pkg::LNK_LO: mem_addr = ptr;      // e
            forth_pkg::LNK_HI: mem_addr = ptr;      // e+1
            forth_pkg::LEN:    mem_addr = ptr;      // e+2
            forth_pkg::NAME:   mem_addr = ptr;
            forth_pkg::TIB:    mem_addr = tptr;
            default:           mem_addr = ptr;      // don't care
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) ctx <= forth_pkg::addr_t'(`CFG_CTX_INIT);
        else if (pop && q_op == forth_pkg::CTX) ctx <= q_addr;
    end

    // datapath registers
    always_ff @(posedge clk) begin
        case (st)
            forth_pkg::IDLE: begin
                if (pop) begin
                    cur_op <= q_op;
                    ptr    <= ctx;                  // newest entry first
                    tib    <= q_addr;
                    hit    <= 1'b0;
                end
            end
            forth_pkg::LNK_LO: begin
                tptr   <= tib;                      // restart string per entry
                at_len <= 1'b1;
                ptr    <= ptr + 1'b1;
            end
            forth_pkg::LNK_HI: begin
                lnk[`CFG_DSZ-1:0] <= mem_rdata;     // link low first
                ptr               <= ptr + 1'b1;
            end
            forth_pkg::LEN: lnk[`CFG_ASZ-1:`CFG_DSZ] <= mem_rdata;
            forth_pkg::TIB: begin
                prev <= mem_rdata;
                ptr  <= ptr + 1'b1;
                if (at_len) begin
                    rem <= mem_rdata;
                    pfa <= ptr + forth_pkg::addr_t'(mem_rdata) + 1'b1;  // e+3+len
                end
            end
            forth_pkg::CMP: begin
                at_len <= 1'b0;
                if (!same) begin
                    ptr <= lnk;                     // follow the chain
                end else if (rem == '0) begin
                    hit <= 1'b1;
                end else begin
                    rem  <= rem - 1'b1;
                    tptr <= tptr + 1'b1;
                end
            end
            default: ;                              // NAME, DONE hold
        endcase
    end

    // response, one pulse out of DONE
    always_ff @(posedge clk) begin
        if (rst) rsp_valid <= 1'b0;
        else rsp_valid <= (st == forth_pkg::DONE);
    end

    always_ff @(posedge clk) begin
        if (st == forth_pkg::DONE) begin
            rsp_op   <= cur_op;
            rsp_data <= (cur_op == forth_pkg::R1) ? mem_rdata : '0;
            rsp_hit  <= hit;
            rsp_pfa  <= hit ? pfa : '0;             // zero on miss
        end
    end

endmodule

// ==== hdl/forth_pool_top.sv ====
/* forth dictionary engine top
   command queue, search engine and dictionary memory */
`timescale 1ns/100ps

module forth_pool_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  forth_pkg::pool_op_e cmd_op,
    input  forth_pkg::addr_t    cmd_addr,
    input  forth_pkg::byte_t    cmd_data,
    output logic                cmd_credit,
    output logic                rsp_valid,
    output forth_pkg::pool_op_e rsp_op,
    output forth_pkg::byte_t    rsp_data,
    output logic                rsp_hit,
    output forth_pkg::addr_t    rsp_pfa
);
    logic                q_valid;      // queue head to engine
    logic                q_ready;
    forth_pkg::pool_op_e q_op;
    forth_pkg::addr_t    q_addr;
    forth_pkg::byte_t    q_data;
    logic                mem_we;       // engine to ram
    forth_pkg::addr_t    mem_addr;
    forth_pkg::byte_t    mem_wdata;
    forth_pkg::byte_t    mem_rdata;

    pool_cmd_queue i_queue (
        .clk, .rst, .cmd_valid, .cmd_op, .cmd_addr, .cmd_data, .cmd_credit,
        .q_valid, .q_ready, .q_op, .q_addr, .q_data
    );

    dict_pool i_pool (
        .clk, .rst, .q_valid, .q_op, .q_addr, .q_data, .q_ready,
        .mem_rdata, .mem_we, .mem_addr, .mem_wdata,
        .rsp_valid, .rsp_op, .rsp_data, .rsp_hit, .rsp_pfa
    );

    dict_mem i_mem (
        .clk,
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// ==== verif/tb_forth_pool.sv ====
/* forth dictionary engine testbench
   random byte traffic, dictionary build and find, credit flow against a model */
`timescale 1ns/100ps
`include "forth_cfg.svh"

module tb_forth_pool;
    localparam int TMO = 2000;                           // cycles per wait
    localparam forth_pkg::addr_t DICT_BASE = 16'h1000;   // first entry
    localparam forth_pkg::addr_t TIB_AD    = 16'h0100;   // terminal input buffer

    logic                clk;
    logic                rst;
    logic                cmd_valid;
    forth_pkg::pool_op_e cmd_op;
    forth_pkg::addr_t    cmd_addr;
    forth_pkg::byte_t    cmd_data;
    logic                cmd_credit;
    logic                rsp_valid;
    forth_pkg::pool_op_e rsp_op;
    forth_pkg::byte_t    rsp_data;
    logic                rsp_hit;
    forth_pkg::addr_t    rsp_pfa;

    int                  seed = 32'h36d6de40;
    int                  credits;                // host side credit count
    int                  min_cred;               // lowest count seen in a burst
    int                  sent;
    int                  returned;
    forth_pkg::addr_t    ctx_m;                  // mirrored context
    forth_pkg::byte_t    mirror [`CFG_MEM_DEPTH];
    forth_pkg::byte_t    str [8];                // counted string for the tib
    int                  str_len;
    forth_pkg::byte_t    names [10][8];          // dictionary words
    int                  name_len [10];
    int                  n_ent;

    forth_pkg::pool_op_e exp_op [$];             // expected responses in order
    forth_pkg::byte_t    exp_data [$];
    logic                exp_hit [$];
    forth_pkg::addr_t    exp_pfa [$];
    forth_pkg::pool_op_e got_op [$];             // captured from the DUT
    forth_pkg::byte_t    got_data [$];
    logic                got_hit [$];
    forth_pkg::addr_t    got_pfa [$];

    forth_pool_top i_dut (
        .clk, .rst, .cmd_valid, .cmd_op, .cmd_addr, .cmd_data,
        .cmd_credit, .rsp_valid, .rsp_op, .rsp_data, .rsp_hit, .rsp_pfa
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;                       // 40 ns period

    // credits and responses sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && rsp_valid) begin
            got_op.push_back(rsp_op);
            got_data.push_back(rsp_data);
            got_hit.push_back(rsp_hit);
            got_pfa.push_back(rsp_pfa);
        end
        if (!rst && cmd_credit) begin
            credits++;
            returned++;
        end
        if (credits > `CFG_CREDITS) begin
            $display("the queue returned a credit for no command");
            $display("** FAIL **");
            $fatal(1, "credit overflow");
        end
    end

    function automatic int rnd(input int range);
        int r;
        r = $unsigned($random(seed)) % range;
        return r;
    endfunction

    // walk the mirrored chain from the context newest first
    function automatic void model_find(input forth_pkg::addr_t tib, output logic hit,
                                       output forth_pkg::addr_t pfa);
        forth_pkg::addr_t e;
        int               len;
        int               steps;
        logic             ok;
        hit   = 1'b0;
        pfa   = '0;
        e     = ctx_m;
        steps = 0;
        while (e != forth_pkg::addr_t'(`CFG_LINK_END) && !hit && steps < 4096) begin
            len = int'(mirror[e + forth_pkg::addr_t'(2)]);
            ok  = (mirror[e + forth_pkg::addr_t'(2)] == mirror[tib]);  // count byte
            for (int i = 0; i < len && ok; i++) begin
                if (mirror[e + forth_pkg::addr_t'(3 + i)] !=
                    mirror[tib + forth_pkg::addr_t'(1 + i)])
                    ok = 1'b0;
            end
            if (ok) begin
                hit = 1'b1;
                pfa = e + forth_pkg::addr_t'(3 + len);
            end else begin
                e = {mirror[e + forth_pkg::addr_t'(1)], mirror[e]};     // link low byte first
            end
            steps++;
        end
    endfunction

    task automatic check_op(input string name, input forth_pkg::pool_op_e exp,
                            input forth_pkg::pool_op_e act);
        if (exp !== act) begin
            $display("Error %s: expected op %s, actual op %s", name, exp.name(), act.name());
            $display("** FAIL **");
            $fatal(1, "opcode mismatch");
        end
    endtask

    task automatic check_byte(input string name, input forth_pkg::byte_t exp,
                              input forth_pkg::byte_t act);
        if (exp !== act) begin
            $display("Error %s: expected data %02h, actual data %02h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_find(input string name, input logic exp_h, input forth_pkg::addr_t exp_p,
                              input logic act_h, input forth_pkg::addr_t act_p);
        if ({exp_h, exp_p} !== {act_h, act_p}) begin
            $display("Error %s: expected hit %b pfa %04h, actual hit %b pfa %04h",
                     name, exp_h, exp_p, act_h, act_p);
            $display("** FAIL **");
            $fatal(1, "find mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "count mismatch");
        end
    endtask

    // model update and one command cycle, stalls while out of credit
    task automatic send(input forth_pkg::pool_op_e op, input forth_pkg::addr_t a,
                        input forth_pkg::byte_t d);
        int               t;
        logic             hit;
        forth_pkg::addr_t pfa;
        t = 0;
        while (credits == 0 && t < TMO) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (credits == 0) begin
            $display("no credit came back from the command queue");
            $display("** FAIL **");
            $fatal(1, "credit timeout");
        end else begin
            case (op)
                forth_pkg::W1:  mirror[a] = d;
                forth_pkg::CTX: ctx_m = a;
                default: begin
                    model_find(a, hit, pfa);
                    exp_op.push_back(op);
                    exp_data.push_back(mirror[a]);       // only used for R1
                    exp_hit.push_back(hit);
                    exp_pfa.push_back(pfa);
                end
            endcase
            cmd_valid = 1'b1;
            cmd_op    = op;
            cmd_addr  = a;
            cmd_data  = d;
            credits--;
            sent++;
            if (credits < min_cred) min_cred = credits;
            @(posedge clk);
            #2;
            cmd_valid = 1'b0;
        end
    endtask

    task automatic check_rsp(input string name);
        int t;
        t = 0;
        while (got_op.size() == 0 && t < TMO) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (got_op.size() == 0) begin
            $display("%s: the engine gave no response", name);
            $display("** FAIL **");
            $fatal(1, "response timeout");
        end else begin
            check_op(name, exp_op[0], got_op[0]);
            if (exp_op[0] == forth_pkg::R1) check_byte(name, exp_data[0], got_data[0]);
            else check_find(name, exp_hit[0], exp_pfa[0], got_hit[0], got_pfa[0]);
            exp_op.delete(0);
            exp_data.delete(0);
            exp_hit.delete(0);
            exp_pfa.delete(0);
            got_op.delete(0);
            got_data.delete(0);
            got_hit.delete(0);
            got_pfa.delete(0);
        end
    endtask

    task automatic drain(input string name);
        while (exp_op.size() > 0) check_rsp(name);
    endtask

    // counted string into the tib then find it
    task automatic put_str();
        send(forth_pkg::W1, TIB_AD, forth_pkg::byte_t'(str_len));
        for (int i = 0; i < str_len; i++) begin
            send(forth_pkg::W1, TIB_AD + forth_pkg::addr_t'(1 + i), str[i]);
        end
    endtask

    task automatic find_str(input string name);
        put_str();
        send(forth_pkg::FIND, TIB_AD, 8'h00);
        check_rsp(name);
    endtask

    task automatic load_str(input int k, input int len);
        for (int i = 0; i < 8; i++) str[i] = names[k][i];
        str_len = len;
    endtask

    // entries packed upward and each linked to the one before
    task automatic build_dict();
        forth_pkg::addr_t e;
        forth_pkg::addr_t prev;
        prev  = forth_pkg::addr_t'(`CFG_LINK_END);
        e     = DICT_BASE;
        n_ent = 6 + rnd(5);
        for (int k = 0; k < n_ent; k++) begin
            name_len[k] = 1 + rnd(8);
            for (int i = 0; i < 8; i++) names[k][i] = forth_pkg::byte_t'(8'h41 + rnd(26));
            if (k == n_ent - 1) begin                    // redefine the oldest word
                name_len[k] = name_len[0];
                names[k]    = names[0];
            end
            send(forth_pkg::W1, e, prev[7:0]);
            send(forth_pkg::W1, e + forth_pkg::addr_t'(1), prev[15:8]);
            send(forth_pkg::W1, e + forth_pkg::addr_t'(2), forth_pkg::byte_t'(name_len[k]));
            for (int i = 0; i < name_len[k]; i++)
                send(forth_pkg::W1, e + forth_pkg::addr_t'(3 + i), names[k][i]);
            prev = e;
            e    = e + forth_pkg::addr_t'(3 + name_len[k]);
        end
        send(forth_pkg::CTX, prev, 8'h00);               // newest entry
    endtask

    initial begin
        int               t;
        forth_pkg::addr_t a;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = forth_pkg::R1;
        cmd_addr  = '0;
        cmd_data  = '0;
        credits   = `CFG_CREDITS;
        min_cred  = `CFG_CREDITS;
        sent      = 0;
        returned  = 0;
        ctx_m     = forth_pkg::addr_t'(`CFG_CTX_INIT);
        for (int i = 0; i < `CFG_MEM_DEPTH; i++) mirror[i] = 8'h00;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // byte traffic mostly in a small window so reads hit writes
        for (int n = 0; n < 200; n++) begin
            if (rnd(4) == 0) a = forth_pkg::addr_t'(rnd(65536));
            else a = forth_pkg::addr_t'(16'h8000 + rnd(64));
            if (rnd(2) != 0) send(forth_pkg::W1, a, forth_pkg::byte_t'(rnd(256)));
            else send(forth_pkg::R1, a, 8'h00);
        end
        drain("byte read write");

        // empty dictionary after reset
        str_len = 1 + rnd(8);
        for (int i = 0; i < 8; i++) str[i] = forth_pkg::byte_t'(8'h41 + rnd(26));
        find_str("find before ctx");

        build_dict();
        for (int k = 0; k < n_ent; k++) begin
            load_str(k, name_len[k]);
            find_str("find stored word");
        end

        // lower case never stored so these miss
        for (int n = 0; n < 8; n++) begin
            str_len = 1 + rnd(8);
            for (int i = 0; i < 8; i++) str[i] = forth_pkg::byte_t'(8'h61 + rnd(26));
            find_str("find absent word");
        end
        for (int k = 0; k < n_ent; k++) begin
            if (name_len[k] > 1) begin
                load_str(k, name_len[k] - 1);
                find_str("find prefix");
            end
            load_str(k, name_len[k]);
            str[name_len[k] - 1] = str[name_len[k] - 1] ^ 8'h80;
            find_str("find last byte changed");
        end

        // back to back mix so credits run dry behind long finds
        load_str(0, name_len[0]);
        put_str();
        min_cred = credits;
        for (int n = 0; n < 40; n++) begin
            if (rnd(2) != 0) send(forth_pkg::R1, DICT_BASE + forth_pkg::addr_t'(rnd(64)), 8'h00);
            else send(forth_pkg::FIND, TIB_AD, 8'h00);
        end
        drain("burst");
        t = 0;
        while (credits != `CFG_CREDITS && t < TMO) begin
            @(posedge clk);
            t++;
        end
        check_count("credits exhausted in burst", 0, min_cred);
        check_count("credits returned", sent, returned);
        check_count("unexpected responses", 0, got_op.size());

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/forth_pkg.sv
hdl/dict_mem.sv
hdl/pool_cmd_queue.sv
hdl/dict_pool.sv
hdl/forth_pool_top.sv
verif/tb_forth_pool.sv

// ==== Makefile ====
# Verilator flow for the forth dictionary engine
TOP = tb_forth_pool

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module $(TOP)

# the binary exits non-zero on $$fatal, so make fails with the test
sim:
	verilator --binary -j 0 -f sources.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
